// ==== rtl/radio_pd_pkg.sv ====
`default_nettype none

package radio_pd_pkg;

  // ----------------------------------------------------------------------
  // Datapath widths
  // ----------------------------------------------------------------------

  // TX I or Q sample, CORDIC output already scaled down
  typedef logic signed [15:0] sample_t;

  // One correction table entry, signed
  typedef logic signed [12:0] lut_val_t;

  // Word to the 12-bit DAC
  typedef logic [11:0] dac_t;

  // ----------------------------------------------------------------------
  // Command slave port
  // ----------------------------------------------------------------------

  // Command address
  typedef logic [5:0] cmd_addr_t;

  // Command data, also used for the audio stream word
  typedef logic [31:0] cmd_data_t;

  // Predistortion mode, taken from command data bits 17..16
  // Reserved codes fall back to the plain sample
  typedef enum logic [1:0] {
    PD_OFF  = 2'd0,
    PD_ON   = 2'd1,
    PD_RSV2 = 2'd2,
    PD_RSV3 = 2'd3
  } pd_mode_e;

  // Predistortion control command
  localparam cmd_addr_t CMD_ADDR_PD = 6'h2b;

  // Sub-index in data bits 31..24 that selects the mode update
  localparam logic [7:0] PD_SUBINDEX = 8'h00;

  // ----------------------------------------------------------------------
  // Timing
  // ----------------------------------------------------------------------

  // Cycles from a TX sample to its DAC word, same in every mode
  localparam int PD_LATENCY = 3;

endpackage

`default_nettype wire

// ==== rtl/pd_ctrl.sv ====
`default_nettype none

module pd_ctrl #(
  parameter int LUT_ADDR_W = 12
) (
  input  wire                          clk_ad9866,
  input  wire                          rst_n_i,

  // Command slave port
  input  wire radio_pd_pkg::cmd_addr_t cmd_addr_i,
  input  wire radio_pd_pkg::cmd_data_t cmd_data_i,
  input  wire                          cmd_rqst_i,

  // Side audio stream carrying table entries
  input  wire radio_pd_pkg::cmd_data_t lr_tdata_i,
  input  wire                          lr_tvalid_i,

  // Current predistortion mode
  output radio_pd_pkg::pd_mode_e       pd_mode_o,

  // Table write port
  output logic                         lut_wr_amp_o,
  output logic                         lut_wr_phase_o,
  output logic [LUT_ADDR_W-1:0]        lut_wr_addr_o,
  output radio_pd_pkg::lut_val_t       lut_wr_data_o
);

  import radio_pd_pkg::*;

  // Stream word layout
  localparam int LR_SEL_BIT   = 28;
  localparam int LR_ADDR_LSB  = 16;
  localparam int LR_VALUE_MSB = 12;

  logic pd_cmd_hit;
  logic lr_sel_phase;

  // ----------------------------------------------------------------------
  // Command decode
  // ----------------------------------------------------------------------

  // Only the PD command with sub-index zero touches the mode
  // Everything else on the port is ignored here
  assign pd_cmd_hit = cmd_rqst_i &&
                      (cmd_addr_i == CMD_ADDR_PD) &&
                      (cmd_data_i[31:24] == PD_SUBINDEX);

  // Mode register, updated on the edge that samples the request
  always_ff @(posedge clk_ad9866 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pd_mode_o <= PD_OFF;
    end else if (pd_cmd_hit) begin
      pd_mode_o <= pd_mode_e'(cmd_data_i[17:16]);
    end
  end

  // ----------------------------------------------------------------------
  // Stream to table writes
  // ----------------------------------------------------------------------

  // Bit 28 high selects the phase curve
  assign lr_sel_phase = lr_tdata_i[LR_SEL_BIT];

  // One-hot strobes, one per valid beat
  always_ff @(posedge clk_ad9866 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lut_wr_amp_o   <= 1'b0;
      lut_wr_phase_o <= 1'b0;
    end else begin
      lut_wr_amp_o   <= lr_tvalid_i && !lr_sel_phase;
      lut_wr_phase_o <= lr_tvalid_i && lr_sel_phase;
    end
  end

  // Address and value follow the strobe by the same cycle
  always_ff @(posedge clk_ad9866) begin
    if (lr_tvalid_i) begin
      lut_wr_addr_o <= lr_tdata_i[LR_ADDR_LSB +: LUT_ADDR_W];
      lut_wr_data_o <= lut_val_t'(lr_tdata_i[LR_VALUE_MSB:0]);
    end
  end

  // Never write both curves from one beat
  a_wr_onehot : assert property (
    @(posedge clk_ad9866) disable iff (!rst_n_i)
    !(lut_wr_amp_o && lut_wr_phase_o)
  ) else $error("pd_ctrl: amplitude and phase strobes both high");

endmodule

`default_nettype wire

// ==== rtl/pd_lut.sv ====
`default_nettype none

module pd_lut #(
  parameter int LUT_ADDR_W = 12
) (
  input  wire                         clk_ad9866,

  // Write port from the control decoder
  input  wire                         lut_wr_amp_i,
  input  wire                         lut_wr_phase_i,
  input  wire [LUT_ADDR_W-1:0]        lut_wr_addr_i,
  input  wire radio_pd_pkg::lut_val_t lut_wr_data_i,

  // Read addresses from the shaper
  input  wire [LUT_ADDR_W-1:0]        rd_amp_a_addr_i,
  input  wire [LUT_ADDR_W-1:0]        rd_amp_b_addr_i,
  input  wire [LUT_ADDR_W-1:0]        rd_phase_addr_i,

  // Registered read data
  output radio_pd_pkg::lut_val_t      rd_amp_a_o,
  output radio_pd_pkg::lut_val_t      rd_amp_b_o,
  output radio_pd_pkg::lut_val_t      rd_phase_o
);

  import radio_pd_pkg::*;

  localparam int LUT_DEPTH = 1 << LUT_ADDR_W;

  // ----------------------------------------------------------------------
  // Table storage
  // ----------------------------------------------------------------------

  // Index is the signed sample bits, so entries sit in
  // two's-complement order: 0, 1, ... max, -min, ... -1
  lut_val_t amp_lut   [LUT_DEPTH];
  lut_val_t phase_lut [LUT_DEPTH];

  // Amplitude curve write
  always_ff @(posedge clk_ad9866) begin
    if (lut_wr_amp_i) begin
      amp_lut[lut_wr_addr_i] <= lut_wr_data_i;
    end
  end

  // Phase curve write
  always_ff @(posedge clk_ad9866) begin
    if (lut_wr_phase_i) begin
      phase_lut[lut_wr_addr_i] <= lut_wr_data_i;
    end
  end

  // ----------------------------------------------------------------------
  // Read ports
  // ----------------------------------------------------------------------

  // Amplitude curve is looked up at I and at Q in the same cycle
  always_ff @(posedge clk_ad9866) begin
    rd_amp_a_o <= amp_lut[rd_amp_a_addr_i];
    rd_amp_b_o <= amp_lut[rd_amp_b_addr_i];
  end

  // Phase curve looked up at the (I+Q)/sqrt2 index
  always_ff @(posedge clk_ad9866) begin
    rd_phase_o <= phase_lut[rd_phase_addr_i];
  end

  // A strobe must come with a resolved address from the decoder
  a_wr_addr_known : assert property (
    @(posedge clk_ad9866)
    (lut_wr_amp_i || lut_wr_phase_i) |-> !$isunknown(lut_wr_addr_i)
  ) else $error("pd_lut: write strobe with unknown address");

endmodule

`default_nettype wire

// ==== rtl/pd_shaper.sv ====
`default_nettype none

module pd_shaper #(
  parameter int LUT_ADDR_W = 12
) (
  input  wire                         clk_ad9866,
  input  wire                         rst_n_i,

  // Mode from the control decoder
  input  wire radio_pd_pkg::pd_mode_e pd_mode_i,

  // TX samples, one pair every cycle
  input  wire radio_pd_pkg::sample_t  tx_i_i,
  input  wire radio_pd_pkg::sample_t  tx_q_i,

  // Table lookup addresses
  output logic [LUT_ADDR_W-1:0]       rd_amp_a_addr_o,
  output logic [LUT_ADDR_W-1:0]       rd_amp_b_addr_o,
  output logic [LUT_ADDR_W-1:0]       rd_phase_addr_o,

  // Table entries, one cycle after the addresses
  input  wire radio_pd_pkg::lut_val_t rd_amp_a_i,
  input  wire radio_pd_pkg::lut_val_t rd_amp_b_i,
  input  wire radio_pd_pkg::lut_val_t rd_phase_i,

  // DAC word
  output radio_pd_pkg::dac_t          tx_data_dac_o
);

  import radio_pd_pkg::*;

  // Stage 1 registers
  sample_t i_s1;
  sample_t q_s1;
  sample_t sum_s1;

  // sqrt2 approximation of the stage 1 sum
  sample_t sum_rt2;

  // Plain path, second delay to match the table read
  dac_t    plain_s2;

  // Combined correction, 16-bit wrapping
  sample_t pd_sum;

  // ----------------------------------------------------------------------
  // Stage 1: register I, Q and I+Q
  // ----------------------------------------------------------------------

  always_ff @(posedge clk_ad9866 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      i_s1   <= '0;
      q_s1   <= '0;
      sum_s1 <= '0;
    end else begin
      i_s1   <= tx_i_i;
      q_s1   <= tx_q_i;
      // Wraps at 16 bits like the sample itself
      sum_s1 <= sample_t'(tx_i_i + tx_q_i);
    end
  end

  // ----------------------------------------------------------------------
  // Stage 2: sqrt2 approximation and table addressing
  // ----------------------------------------------------------------------

  // S * (1 + 1/4 + 1/8 + 1/32) ~ S * 1.406
  // Residual error is folded into the phase table contents
  assign sum_rt2 = sum_s1 + (sum_s1 >>> 2) + (sum_s1 >>> 3) + (sum_s1 >>> 5);

  // Low bits of signed samples index the tables directly
  assign rd_amp_a_addr_o = i_s1[LUT_ADDR_W-1:0];
  assign rd_amp_b_addr_o = q_s1[LUT_ADDR_W-1:0];

  // Phase index drops bit 0, i.e. (I+Q)/sqrt2 with a halved range
  assign rd_phase_addr_o = sum_rt2[LUT_ADDR_W:1];

  // Plain word waits here while the tables are read
  always_ff @(posedge clk_ad9866 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      plain_s2 <= '0;
    end else begin
      plain_s2 <= i_s1[11:0];
    end
  end

  // ----------------------------------------------------------------------
  // Stage 3: combine and select
  // ----------------------------------------------------------------------

  // amp(I) - amp(Q) + phase(R), entries sign extended to 16 bits
  assign pd_sum = sample_t'(rd_amp_a_i) - sample_t'(rd_amp_b_i) + sample_t'(rd_phase_i);

  // Reserved modes behave as off
  always_ff @(posedge clk_ad9866 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_data_dac_o <= '0;
    end else begin
      case (pd_mode_i)
        PD_ON:   tx_data_dac_o <= pd_sum[11:0];
        default: tx_data_dac_o <= plain_s2;
      endcase
    end
  end

  // Known samples for the whole pipeline depth give a known DAC word
  a_dac_known : assert property (
    @(posedge clk_ad9866) disable iff (!rst_n_i)
    (!$isunknown({tx_i_i, tx_q_i}))[*PD_LATENCY] |=> !$isunknown(tx_data_dac_o)
  ) else $error("pd_shaper: DAC word unknown with known samples");

endmodule

`default_nettype wire

// ==== rtl/radio_pd_top.sv ====
`default_nettype none

module radio_pd_top #(
  parameter int LUT_ADDR_W = 12
) (
  input  wire                          clk_ad9866,
  input  wire                          rst_n_i,

  // Command slave port
  input  wire radio_pd_pkg::cmd_addr_t cmd_addr_i,
  input  wire radio_pd_pkg::cmd_data_t cmd_data_i,
  input  wire                          cmd_rqst_i,

  // Table loading stream
  input  wire radio_pd_pkg::cmd_data_t lr_tdata_i,
  input  wire                          lr_tvalid_i,

  // TX samples in, DAC word out
  input  wire radio_pd_pkg::sample_t   tx_i_i,
  input  wire radio_pd_pkg::sample_t   tx_q_i,
  output radio_pd_pkg::dac_t           tx_data_dac_o
);

  import radio_pd_pkg::*;

  // ----------------------------------------------------------------------
  // Internal wiring
  // ----------------------------------------------------------------------

  pd_mode_e              pd_mode;

  // Decoder to tables
  logic                  lut_wr_amp;
  logic                  lut_wr_phase;
  logic [LUT_ADDR_W-1:0] lut_wr_addr;
  lut_val_t              lut_wr_data;

  // Shaper to tables and back
  logic [LUT_ADDR_W-1:0] rd_amp_a_addr;
  logic [LUT_ADDR_W-1:0] rd_amp_b_addr;
  logic [LUT_ADDR_W-1:0] rd_phase_addr;
  lut_val_t              rd_amp_a;
  lut_val_t              rd_amp_b;
  lut_val_t              rd_phase;

  // Mode and table writes
  pd_ctrl #(.LUT_ADDR_W(LUT_ADDR_W)) u_pd_ctrl (
    .clk_ad9866     (clk_ad9866),
    .rst_n_i        (rst_n_i),
    .cmd_addr_i     (cmd_addr_i),
    .cmd_data_i     (cmd_data_i),
    .cmd_rqst_i     (cmd_rqst_i),
    .lr_tdata_i     (lr_tdata_i),
    .lr_tvalid_i    (lr_tvalid_i),
    .pd_mode_o      (pd_mode),
    .lut_wr_amp_o   (lut_wr_amp),
    .lut_wr_phase_o (lut_wr_phase),
    .lut_wr_addr_o  (lut_wr_addr),
    .lut_wr_data_o  (lut_wr_data)
  );

  // Amplitude and phase correction curves
  pd_lut #(.LUT_ADDR_W(LUT_ADDR_W)) u_pd_lut (
    .clk_ad9866      (clk_ad9866),
    .lut_wr_amp_i    (lut_wr_amp),
    .lut_wr_phase_i  (lut_wr_phase),
    .lut_wr_addr_i   (lut_wr_addr),
    .lut_wr_data_i   (lut_wr_data),
    .rd_amp_a_addr_i (rd_amp_a_addr),
    .rd_amp_b_addr_i (rd_amp_b_addr),
    .rd_phase_addr_i (rd_phase_addr),
    .rd_amp_a_o      (rd_amp_a),
    .rd_amp_b_o      (rd_amp_b),
    .rd_phase_o      (rd_phase)
  );

  // Sample pipeline to the DAC
  pd_shaper #(.LUT_ADDR_W(LUT_ADDR_W)) u_pd_shaper (
    .clk_ad9866      (clk_ad9866),
    .rst_n_i         (rst_n_i),
    .pd_mode_i       (pd_mode),
    .tx_i_i          (tx_i_i),
    .tx_q_i          (tx_q_i),
    .rd_amp_a_addr_o (rd_amp_a_addr),
    .rd_amp_b_addr_o (rd_amp_b_addr),
    .rd_phase_addr_o (rd_phase_addr),
    .rd_amp_a_i      (rd_amp_a),
    .rd_amp_b_i      (rd_amp_b),
    .rd_phase_i      (rd_phase),
    .tx_data_dac_o   (tx_data_dac_o)
  );

endmodule

`default_nettype wire

// ==== verification/tb_pd_model.svh ====
`ifndef TB_PD_MODEL_SVH
`define TB_PD_MODEL_SVH

// Expected contents of both correction curves
lut_val_t amp_model   [LUT_DEPTH];
lut_val_t phase_model [LUT_DEPTH];

// Rule the shaper applies to the oldest sample in flight
pd_mode_e mode_model = PD_OFF;

// Phase curve index from (I+Q) scaled by 1 + 1/4 + 1/8 + 1/32
function automatic logic [LUT_ADDR_W-1:0] phase_index(input sample_t i, input sample_t q);
  int s;
  int r;
  s = int'(i) + int'(q);
  // Wrap to 16 bits, then sign extend again
  s = (s << 16) >>> 16;
  r = s + (s >>> 2) + (s >>> 3) + (s >>> 5);
  // Bit 0 dropped
  return r[LUT_ADDR_W:1];
endfunction

// amp(I) - amp(Q) + phase(index), low 12 bits
function automatic dac_t corrected_word(input sample_t i, input sample_t q);
  logic signed [31:0] acc;
  acc = amp_model[i[LUT_ADDR_W-1:0]];
  acc = acc - amp_model[q[LUT_ADDR_W-1:0]];
  acc = acc + phase_model[phase_index(i, q)];
  return acc[11:0];
endfunction

// Command history word is {rqst, addr, data}
task automatic apply_cmd(input logic [38:0] c);
  if (c[38] && c[37:32] == CMD_ADDR_PD && c[31:24] == PD_SUBINDEX) begin
    mode_model = pd_mode_e'(c[17:16]);
  end
endtask

// Beat history word is {valid, data}; bit 28 picks the phase curve
task automatic apply_beat(input logic [32:0] b);
  if (b[32] && b[28]) begin
    phase_model[b[16 +: LUT_ADDR_W]] = b[12:0];
  end else if (b[32]) begin
    amp_model[b[16 +: LUT_ADDR_W]] = b[12:0];
  end
endtask

`endif

// ==== verification/tb_radio_pd.sv ====
`default_nettype none

module tb_radio_pd;
  timeunit 1ns;
  timeprecision 1ps;

  import radio_pd_pkg::*;

  localparam int LUT_ADDR_W = 12;
  localparam int LUT_DEPTH  = 1 << LUT_ADDR_W;
  localparam int CLK_PERIOD = 8;

  // Cycles per test
  localparam int N_RESET   = 64;
  localparam int N_ON      = 400;
  localparam int N_IGNORE  = 200;
  localparam int N_MODE    = 150;
  localparam int N_REWRITE = 600;
  localparam int N_CYCLES  = 3 + N_RESET + 2 * LUT_DEPTH + 3 + N_ON + N_IGNORE
                             + 5 * (N_MODE + 1) + 1 + N_REWRITE + PD_LATENCY;

  `include "tb_pd_model.svh"

  logic      clk_ad9866 = 1'b0;
  logic      rst_n_i;
  cmd_addr_t cmd_addr_i;
  cmd_data_t cmd_data_i;
  logic      cmd_rqst_i;
  cmd_data_t lr_tdata_i;
  logic      lr_tvalid_i;
  sample_t   tx_i_i;
  sample_t   tx_q_i;
  dac_t      tx_data_dac_o;

  // Stimulus still in flight, oldest first
  logic [38:0] cmd_hist[$];
  logic [32:0] beat_hist[$];
  sample_t     i_hist[$];
  sample_t     q_hist[$];
  string       name_hist[$];

  radio_pd_top #(.LUT_ADDR_W(LUT_ADDR_W)) uut (
    .clk_ad9866    (clk_ad9866),
    .rst_n_i       (rst_n_i),
    .cmd_addr_i    (cmd_addr_i),
    .cmd_data_i    (cmd_data_i),
    .cmd_rqst_i    (cmd_rqst_i),
    .lr_tdata_i    (lr_tdata_i),
    .lr_tvalid_i   (lr_tvalid_i),
    .tx_i_i        (tx_i_i),
    .tx_q_i        (tx_q_i),
    .tx_data_dac_o (tx_data_dac_o)
  );

  always #(CLK_PERIOD / 2) clk_ad9866 = ~clk_ad9866;

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------

  task automatic check_dac(input string name, input dac_t exp, input dac_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      $display("test failed");
      $fatal(1, "DAC word mismatch");
    end
  endtask

  task automatic check_mode(input string name, input pd_mode_e exp, input pd_mode_e act);
    if (act !== exp) begin
      $display("Fail %s: expected %s, actual %s", name, exp.name(), act.name());
      $display("test failed");
      $fatal(1, "Output rule mismatch");
    end
  endtask

  // ----------------------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------------------

  function automatic cmd_data_t rand_word();
    return cmd_data_t'($urandom);
  endfunction

  function automatic sample_t rand_sample();
    return sample_t'($urandom);
  endfunction

  // Random filler around sub-index and mode fields
  function automatic cmd_data_t cmd_word(input logic [7:0] sub, input logic [1:0] mode);
    cmd_data_t w;
    w = rand_word();
    w[31:24] = sub;
    w[17:16] = mode;
    return w;
  endfunction

  // Value in bits 12..0 stays random
  function automatic cmd_data_t beat_word(input logic sel, input logic [LUT_ADDR_W-1:0] addr);
    cmd_data_t w;
    w = rand_word();
    w[28] = sel;
    w[16 +: LUT_ADDR_W] = addr;
    return w;
  endfunction

  // Same-cycle read and write of one entry is undefined
  function automatic logic collides(input cmd_data_t w, input sample_t i, input sample_t q);
    logic [LUT_ADDR_W-1:0] addr;
    addr = w[16 +: LUT_ADDR_W];
    if (w[28]) begin
      return addr == phase_index(i, q);
    end
    return addr == i[LUT_ADDR_W-1:0] || addr == q[LUT_ADDR_W-1:0];
  endfunction

  // One clock: retire the model, check the oldest sample, drive new inputs
  task automatic cycle(input string name, input logic c_v, input cmd_addr_t c_addr,
                       input cmd_data_t c_data, input logic b_v, input cmd_data_t b_data,
                       input sample_t s_i, input sample_t s_q);
    sample_t i_old;
    sample_t q_old;
    string   n_old;
    dac_t    corr;
    dac_t    plain;
    @(negedge clk_ad9866);
    // Mode acts two cycles after its command, a table entry four after its beat
    if (cmd_hist.size() == PD_LATENCY - 1) begin
      apply_cmd(cmd_hist.pop_front());
    end
    if (beat_hist.size() == PD_LATENCY + 1) begin
      apply_beat(beat_hist.pop_front());
    end
    i_old = i_hist.pop_front();
    q_old = q_hist.pop_front();
    n_old = name_hist.pop_front();
    corr  = corrected_word(i_old, q_old);
    plain = i_old[11:0];
    // Which rule did the DAC word follow
    if (!$isunknown(corr) && corr != plain &&
        (tx_data_dac_o === corr || tx_data_dac_o === plain)) begin
      check_mode(n_old, (mode_model == PD_ON) ? PD_ON : PD_OFF,
                 (tx_data_dac_o === corr) ? PD_ON : PD_OFF);
    end
    check_dac(n_old, (mode_model == PD_ON) ? corr : plain, tx_data_dac_o);
    cmd_rqst_i  = c_v;
    cmd_addr_i  = c_addr;
    cmd_data_i  = c_data;
    lr_tvalid_i = b_v;
    lr_tdata_i  = b_data;
    tx_i_i      = s_i;
    tx_q_i      = s_q;
    cmd_hist.push_back({c_v, c_addr, c_data});
    beat_hist.push_back({b_v, b_data});
    i_hist.push_back(s_i);
    q_hist.push_back(s_q);
    name_hist.push_back(name);
  endtask

  // Random samples, no request, no beat
  task automatic idle(input string name);
    cycle(name, 1'b0, cmd_addr_t'($urandom), rand_word(), 1'b0, rand_word(),
          rand_sample(), rand_sample());
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial begin
    pd_mode_e              modes [5];
    cmd_addr_t             a;
    cmd_data_t             w;
    sample_t               si;
    sample_t               sq;
    logic [LUT_ADDR_W-1:0] prev_addr;
    void'($urandom(32'h803d_1a61));
    // Every plain-word mode is entered while the corrected word is active
    modes = '{PD_RSV2, PD_ON, PD_RSV3, PD_ON, PD_OFF};
    rst_n_i     = 1'b0;
    cmd_addr_i  = '0;
    cmd_data_i  = '0;
    cmd_rqst_i  = 1'b0;
    lr_tdata_i  = '0;
    lr_tvalid_i = 1'b0;
    tx_i_i      = '0;
    tx_q_i      = '0;
    repeat (2) @(posedge clk_ad9866);
    @(negedge clk_ad9866);
    rst_n_i = 1'b1;
    check_dac("reset", '0, tx_data_dac_o);
    // Pipeline registers hold zero samples after reset
    repeat (PD_LATENCY) begin
      i_hist.push_back('0);
      q_hist.push_back('0);
      name_hist.push_back("reset");
    end
    repeat (N_RESET) idle("reset");

    // Fill both curves while mode is off
    for (int k = 0; k < 2 * LUT_DEPTH; k++) begin
      cycle("table_load", 1'b0, cmd_addr_t'($urandom), rand_word(), 1'b1,
            beat_word(k >= LUT_DEPTH, LUT_ADDR_W'(k)), rand_sample(), rand_sample());
    end
    // Last writes land before the first corrected read
    repeat (2) idle("table_load");

    cycle("pd_on", 1'b1, CMD_ADDR_PD, cmd_word(PD_SUBINDEX, 2'd1), 1'b0, rand_word(),
          rand_sample(), rand_sample());
    repeat (N_ON) idle("pd_on");

    // Wrong sub-index at the PD address, or zero sub-index elsewhere
    for (int k = 0; k < N_IGNORE; k++) begin
      a = cmd_addr_t'($urandom);
      if (a == CMD_ADDR_PD) begin
        a = a ^ 6'h01;
      end
      w = cmd_word(PD_SUBINDEX, 2'd0);
      if (k % 2 == 1) begin
        a = CMD_ADDR_PD;
        w = cmd_word(8'd1 + 8'($urandom % 255), 2'd0);
      end
      cycle("ignored_cmd", 1'b1, a, w, 1'b0, rand_word(), rand_sample(), rand_sample());
    end

    // Reserved codes and off give the plain word, each entered from on
    foreach (modes[m]) begin
      cycle($sformatf("mode_%0d", modes[m]), 1'b1, CMD_ADDR_PD,
            cmd_word(PD_SUBINDEX, modes[m]), 1'b0, rand_word(), rand_sample(), rand_sample());
      repeat (N_MODE) idle($sformatf("mode_%0d", modes[m]));
    end

    cycle("rewrite", 1'b1, CMD_ADDR_PD, cmd_word(PD_SUBINDEX, 2'd1), 1'b0, rand_word(),
          rand_sample(), rand_sample());
    prev_addr = '0;
    for (int k = 0; k < N_REWRITE; k++) begin
      w  = beat_word(1'($urandom), LUT_ADDR_W'($urandom));
      // I aims at the entry the previous beat just wrote
      si = rand_sample();
      si[LUT_ADDR_W-1:0] = prev_addr;
      sq = rand_sample();
      while (collides(w, si, sq)) begin
        si = rand_sample();
        sq = rand_sample();
      end
      prev_addr = w[16 +: LUT_ADDR_W];
      cycle("rewrite", 1'b0, cmd_addr_t'($urandom), rand_word(), 1'b1, w, si, sq);
    end

    // Flush the samples still in the pipeline
    repeat (PD_LATENCY) idle("drain");
    $display("test passed");
    $finish;
  end

  // Run length plus a margin
  initial begin
    #((N_CYCLES + 100) * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, sequence did not finish", N_CYCLES + 100);
    $display("test failed");
    $fatal(1, "Timeout");
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+verification
rtl/radio_pd_pkg.sv
rtl/pd_ctrl.sv
rtl/pd_lut.sv
rtl/pd_shaper.sv
rtl/radio_pd_top.sv
verification/tb_radio_pd.sv
